// ==== Bender.yml ====
package:
  name: vread

sources:
  - files:
      - design/vread_bus_pkg.sv
      - design/vread_cfg_pkg.sv
      - design/burst_fetch.sv
      - design/pingpong_mem.sv
      - design/loop_stream_out.sv
      - design/vread_top.sv
  - target: test
    files:
      - tb/databus_slave.sv
      - tb/tb_vread.sv

// ==== design/burst_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module burst_fetch
   import vread_bus_pkg::*;
(
   input  logic       clk,
   input  logic       rst,

   input  logic       start_i,
   input  ext_addr_t  ext_addr_i,
   input  mem_addr_t  amount_i,
   input  burst_len_t max_burst_i,

   output logic       databus_valid_o,
   input  logic       databus_ready_i,
   output ext_addr_t  databus_addr_o,
   output burst_len_t databus_len_o,
   input  mem_word_t  databus_rdata_i,
   input  logic       databus_last_i,

   output logic       wr_en_o,
   output mem_addr_t  wr_addr_o,
   output mem_word_t  wr_data_o,

   output logic       done_o
);

   logic       valid_q;
   logic       gap_q;
   logic       done_q;
   mem_addr_t  remain_q;
   mem_addr_t  word_q;
   ext_addr_t  addr_q;
   burst_len_t len_q;
   burst_len_t max_q;
   logic       beat;
   logic       last_beat;
   mem_addr_t  remain_next;

   // length field for the next burst: min(words left, max beats) - 1
   function automatic burst_len_t burst_len(input mem_addr_t words, input burst_len_t max_beats);
      mem_addr_t beats;
      beats = (words < mem_addr_t'(max_beats)) ? words : mem_addr_t'(max_beats);
      return burst_len_t'(beats - 1'b1);
   endfunction

   assign beat        = valid_q & databus_ready_i;
   assign last_beat   = beat & databus_last_i;
   assign remain_next = remain_q - 1'b1;

   // burst sequencing
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         valid_q  <= 1'b0;
         gap_q    <= 1'b0;
         done_q   <= 1'b0;
         remain_q <= '0;
         word_q   <= '0;
      end else begin
         done_q <= 1'b0;
         if (start_i) begin
            remain_q <= amount_i;
            word_q   <= '0;
            gap_q    <= 1'b0;
            valid_q  <= (amount_i != '0);
            // nothing to fetch, report at once
            done_q   <= (amount_i == '0);
         end else begin
            if (beat) begin
               remain_q <= remain_next;
               word_q   <= word_q + 1'b1;
            end
            if (last_beat) begin
               // one idle cycle between bursts
               valid_q <= 1'b0;
               gap_q   <= (remain_next != '0);
               done_q  <= (remain_next == '0);
            end else if (gap_q) begin
               valid_q <= 1'b1;
               gap_q   <= 1'b0;
            end
         end
      end
   end

   // address and length held steady for the whole burst
   always_ff @(posedge clk) begin
      if (start_i) begin
         addr_q <= ext_addr_i;
         max_q  <= max_burst_i;
         len_q  <= burst_len(amount_i, max_burst_i);
      end else if (last_beat) begin
         addr_q <= ext_addr_t'(addr_q + (ext_addr_t'(len_q) + 1'b1) * BYTES_PER_WORD);
      end else if (gap_q) begin
         len_q <= burst_len(remain_q, max_q);
      end
   end

   assign databus_valid_o = valid_q;
   assign databus_addr_o  = addr_q;
   assign databus_len_o   = len_q;

   // every accepted beat lands in the next word of the fill bank
   assign wr_en_o   = beat;
   assign wr_addr_o = word_q;
   assign wr_data_o = databus_rdata_i;

   assign done_o = done_q;

endmodule

`default_nettype wire

// ==== design/loop_stream_out.sv ====
`timescale 1ns/1ps
`default_nettype none

module loop_stream_out
   import vread_bus_pkg::*;
   import vread_cfg_pkg::*;
(
   input  logic       clk,
   input  logic       rst,

   input  logic       start_i,
   input  delay_t     delay_i,
   input  elem_addr_t start_addr_i,
   input  period_t    per_i,
   input  elem_addr_t incr_i,
   input  period_t    iter_i,
   input  elem_addr_t shift_i,

   output logic       rd_en_o,
   output mem_addr_t  rd_addr_o,
   input  mem_word_t  rd_data_i,

   output logic       out_valid_o,
   output data_t      out_data_o,
   output logic       done_o
);

   logic              wait_q;
   logic              active_q;
   logic              out_valid_q;
   logic              done_q;
   delay_t            delay_q;
   period_t           inner_q;
   period_t           outer_q;
   period_t           per_q;
   elem_addr_t        addr_q;
   elem_addr_t        base_q;
   elem_addr_t        incr_q;
   elem_addr_t        shift_q;
   logic [LANE_W-1:0] lane_q;
   logic              empty;
   logic              inner_end;
   logic              final_rd;

   assign empty     = (per_i == '0) || (iter_i == '0);
   assign inner_end = (inner_q == '0);
   assign final_rd  = active_q & inner_end & (outer_q == '0);

   // delay counter, then the two loop counters counting down
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wait_q      <= 1'b0;
         active_q    <= 1'b0;
         out_valid_q <= 1'b0;
         done_q      <= 1'b0;
         delay_q     <= '0;
         inner_q     <= '0;
         outer_q     <= '0;
      end else begin
         out_valid_q <= active_q;
         if (start_i) begin
            wait_q   <= ~empty & (delay_i != '0);
            active_q <= ~empty & (delay_i == '0);
            delay_q  <= delay_i - 1'b1;
            inner_q  <= per_i - 1'b1;
            outer_q  <= iter_i - 1'b1;
            done_q   <= empty;
         end else begin
            // high while the last word is on the output
            done_q <= final_rd;
            if (wait_q) begin
               if (delay_q == '0) begin
                  wait_q   <= 1'b0;
                  active_q <= 1'b1;
               end else begin
                  delay_q <= delay_q - 1'b1;
               end
            end
            if (active_q) begin
               if (!inner_end) begin
                  inner_q <= inner_q - 1'b1;
               end else if (outer_q != '0) begin
                  inner_q <= per_q - 1'b1;
                  outer_q <= outer_q - 1'b1;
               end else begin
                  active_q <= 1'b0;
               end
            end
         end
      end
   end

   // element (i, j) = start + i*shift + j*incr
   always_ff @(posedge clk) begin
      if (start_i) begin
         per_q   <= per_i;
         incr_q  <= incr_i;
         shift_q <= shift_i;
         addr_q  <= start_addr_i;
         base_q  <= start_addr_i;
      end else if (active_q) begin
         if (!inner_end) begin
            addr_q <= addr_q + incr_q;
         end else begin
            base_q <= base_q + shift_q;
            addr_q <= base_q + shift_q;
         end
      end
      // lane follows the read by one cycle, like the data
      lane_q <= addr_q[LANE_W-1:0];
   end

   assign rd_en_o   = active_q;
   assign rd_addr_o = addr_q[ELEM_ADDR_W-1:LANE_W];

   assign out_valid_o = out_valid_q;
   assign out_data_o  = rd_data_i[lane_q*DATA_W +: DATA_W];
   assign done_o      = done_q;

endmodule

`default_nettype wire

// ==== design/pingpong_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module pingpong_mem
   import vread_bus_pkg::*;
(
   input  logic      clk,

   input  logic      wr_en_i,
   input  logic      wr_bank_i,
   input  mem_addr_t wr_addr_i,
   input  mem_word_t wr_data_i,

   input  logic      rd_en_i,
   input  logic      rd_bank_i,
   input  mem_addr_t rd_addr_i,
   output mem_word_t rd_data_o
);

   // both banks in one array, bank bit on top of the word address
   mem_word_t mem [2*MEM_DEPTH];

   logic [MEM_ADDR_W:0] wr_index;
   logic [MEM_ADDR_W:0] rd_index;

   assign wr_index = {wr_bank_i, wr_addr_i};
   assign rd_index = {rd_bank_i, rd_addr_i};

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_index] <= wr_data_i;
      end
   end

   // registered read, data valid one cycle after rd_en
   always_ff @(posedge clk) begin
      if (rd_en_i) begin
         rd_data_o <= mem[rd_index];
      end
   end

endmodule

`default_nettype wire

// ==== design/vread_bus_pkg.sv ====
`default_nettype none

package vread_bus_pkg;

   // external databus
   localparam int AXI_ADDR_W = 32;
   localparam int AXI_DATA_W = 32;

   // burst length field carries beats minus one
   localparam int LEN_W = 8;

   // word address inside one bank of the local memory
   localparam int MEM_ADDR_W = 10;
   localparam int MEM_DEPTH  = 2 ** MEM_ADDR_W;

   // byte step of the external address per beat
   localparam int BYTES_PER_WORD = AXI_DATA_W / 8;

   typedef logic [AXI_ADDR_W-1:0] ext_addr_t;
   typedef logic [AXI_DATA_W-1:0] mem_word_t;
   typedef logic [LEN_W-1:0]      burst_len_t;
   typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

endpackage

`default_nettype wire

// ==== design/vread_cfg_pkg.sv ====
`default_nettype none

package vread_cfg_pkg;

   import vread_bus_pkg::*;

   // output word width
   localparam int DATA_W = 8;

   // byte lanes of one memory word, lane 0 is the low byte
   localparam int LANES  = AXI_DATA_W / DATA_W;
   localparam int LANE_W = $clog2(LANES);

   // element address = {word address, lane}
   localparam int ELEM_ADDR_W = MEM_ADDR_W + LANE_W;

   // loop configuration
   localparam int PERIOD_W = 10;
   localparam int DELAY_W  = 7;

   typedef logic [ELEM_ADDR_W-1:0] elem_addr_t;
   typedef logic [PERIOD_W-1:0]    period_t;
   typedef logic [DELAY_W-1:0]     delay_t;
   typedef logic [DATA_W-1:0]      data_t;

endpackage

`default_nettype wire

// ==== design/vread_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module vread_top
   import vread_bus_pkg::*;
   import vread_cfg_pkg::*;
(
   input  logic       clk,
   input  logic       rst,

   input  logic       run_i,
   input  logic       ping_pong_i,

   // fetch configuration
   input  ext_addr_t  ext_addr_i,
   input  mem_addr_t  amount_i,
   input  burst_len_t max_burst_i,

   // output loop configuration
   input  delay_t     delay_i,
   input  elem_addr_t start_addr_i,
   input  period_t    per_i,
   input  elem_addr_t incr_i,
   input  period_t    iter_i,
   input  elem_addr_t shift_i,

   output logic       databus_valid_o,
   input  logic       databus_ready_i,
   output ext_addr_t  databus_addr_o,
   output burst_len_t databus_len_o,
   input  mem_word_t  databus_rdata_i,
   input  logic       databus_last_i,

   output logic       out_valid_o,
   output data_t      out_data_o,
   output logic       done_o
);

   logic      bank_q;
   logic      pp_q;
   logic      fetch_done_q;
   logic      out_done_q;
   logic      fill_bank;
   logic      drain_bank;
   logic      fetch_done;
   logic      out_done;
   logic      wr_en;
   mem_addr_t wr_addr;
   mem_word_t wr_data;
   logic      rd_en;
   mem_addr_t rd_addr;
   mem_word_t rd_data;

   // bank toggles per run with ping-pong, otherwise stays on bank 0
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         bank_q <= 1'b0;
         pp_q   <= 1'b0;
      end else if (run_i) begin
         bank_q <= ping_pong_i ? ~bank_q : 1'b0;
         pp_q   <= ping_pong_i;
      end
   end

   assign fill_bank  = bank_q;
   assign drain_bank = pp_q ? ~bank_q : 1'b0;

   // per side done flags, set by the pulses of each side
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         fetch_done_q <= 1'b1;
         out_done_q   <= 1'b1;
      end else if (run_i) begin
         fetch_done_q <= 1'b0;
         out_done_q   <= 1'b0;
      end else begin
         if (fetch_done) begin
            fetch_done_q <= 1'b1;
         end
         if (out_done) begin
            out_done_q <= 1'b1;
         end
      end
   end

   assign done_o = fetch_done_q & out_done_q;

   burst_fetch i_burst_fetch (
      .clk             (clk),
      .rst             (rst),
      .start_i         (run_i),
      .ext_addr_i      (ext_addr_i),
      .amount_i        (amount_i),
      .max_burst_i     (max_burst_i),
      .databus_valid_o (databus_valid_o),
      .databus_ready_i (databus_ready_i),
      .databus_addr_o  (databus_addr_o),
      .databus_len_o   (databus_len_o),
      .databus_rdata_i (databus_rdata_i),
      .databus_last_i  (databus_last_i),
      .wr_en_o         (wr_en),
      .wr_addr_o       (wr_addr),
      .wr_data_o       (wr_data),
      .done_o          (fetch_done)
   );

   pingpong_mem i_pingpong_mem (
      .clk       (clk),
      .wr_en_i   (wr_en),
      .wr_bank_i (fill_bank),
      .wr_addr_i (wr_addr),
      .wr_data_i (wr_data),
      .rd_en_i   (rd_en),
      .rd_bank_i (drain_bank),
      .rd_addr_i (rd_addr),
      .rd_data_o (rd_data)
   );

   loop_stream_out i_loop_stream_out (
      .clk          (clk),
      .rst          (rst),
      .start_i      (run_i),
      .delay_i      (delay_i),
      .start_addr_i (start_addr_i),
      .per_i        (per_i),
      .incr_i       (incr_i),
      .iter_i       (iter_i),
      .shift_i      (shift_i),
      .rd_en_o      (rd_en),
      .rd_addr_o    (rd_addr),
      .rd_data_i    (rd_data),
      .out_valid_o  (out_valid_o),
      .out_data_o   (out_data_o),
      .done_o       (out_done)
   );

endmodule

`default_nettype wire

// ==== tb.f ====
design/vread_bus_pkg.sv
design/vread_cfg_pkg.sv
design/burst_fetch.sv
design/pingpong_mem.sv
design/loop_stream_out.sv
design/vread_top.sv
tb/databus_slave.sv
tb/tb_vread.sv

// ==== tb/databus_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module databus_slave
   import vread_bus_pkg::*;
(
   input  logic       clk,
   input  logic       rst,

   input  logic       valid_i,
   output logic       ready_o,
   input  ext_addr_t  addr_i,
   input  burst_len_t len_i,
   output mem_word_t  rdata_o,
   output logic       last_o
);

   localparam int TABLE_W = 12;

   mem_word_t  rand_words [2**TABLE_W];
   burst_len_t beat_q;
   burst_len_t next_beat;

   task automatic fill_memory();
      for (int i = 0; i < 2**TABLE_W; i++) begin
         rand_words[i] = $urandom;
      end
   endtask

   // table repeats every 16 KiB, the xor keeps upper address bits in the data
   function automatic mem_word_t read_word(input ext_addr_t addr);
      return rand_words[addr[TABLE_W+1:2]] ^ mem_word_t'(addr);
   endfunction

   // ready only after valid was seen, so addr and len are settled
   always @(posedge clk or posedge rst) begin
      if (rst) begin
         ready_o <= 1'b0;
         rdata_o <= '0;
         last_o  <= 1'b0;
         beat_q  <= '0;
      end else begin
         next_beat = beat_q;
         if (valid_i && ready_o) begin
            next_beat = last_o ? '0 : burst_len_t'(beat_q + 1'b1);
         end
         beat_q  <= next_beat;
         ready_o <= valid_i && (($urandom % 4) != 0);
         rdata_o <= read_word(ext_addr_t'(addr_i + ext_addr_t'(next_beat) * BYTES_PER_WORD));
         last_o  <= (next_beat == len_i);
      end
   end

endmodule

`default_nettype wire

// ==== tb/tb_vread.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_vread
   import vread_bus_pkg::*;
   import vread_cfg_pkg::*;
();

   localparam int NUM_RUNS    = 12;
   localparam int IDLE_CYCLES = 2;

   logic       clk;
   logic       rst;
   logic       run;
   logic       ping_pong;
   ext_addr_t  ext_addr;
   mem_addr_t  amount;
   burst_len_t max_burst;
   delay_t     delay;
   elem_addr_t start_addr;
   period_t    per;
   elem_addr_t incr;
   period_t    iter;
   elem_addr_t shift;
   logic       databus_valid;
   logic       databus_ready;
   ext_addr_t  databus_addr;
   burst_len_t databus_len;
   mem_word_t  databus_rdata;
   logic       databus_last;
   logic       out_valid;
   data_t      out_data;
   logic       done;

   // run configurations, drawn before the first run
   logic       cfg_pp     [NUM_RUNS];
   ext_addr_t  cfg_addr   [NUM_RUNS];
   mem_addr_t  cfg_amount [NUM_RUNS];
   burst_len_t cfg_maxb   [NUM_RUNS];
   delay_t     cfg_delay  [NUM_RUNS];
   elem_addr_t cfg_start  [NUM_RUNS];
   period_t    cfg_per    [NUM_RUNS];
   elem_addr_t cfg_incr   [NUM_RUNS];
   period_t    cfg_iter   [NUM_RUNS];
   elem_addr_t cfg_shift  [NUM_RUNS];

   // reference model state
   mem_word_t  shadow [2][MEM_DEPTH];
   logic       model_bank;
   ext_addr_t  exp_addr_q [$];
   burst_len_t exp_len_q [$];
   data_t      exp_data_q [$];

   // monitor state
   int          cyc;
   int          limit;
   int          errors;
   int          run_cycle;
   int          out_cnt;
   int          beat_cnt;
   int          cur_delay;
   int          cur_amount;
   int          cur_reads;
   logic        busy;
   logic        first_cycle;
   logic        in_burst;
   ext_addr_t   burst_addr;
   burst_len_t  burst_len;
   int unsigned seed_draw;
   event        run_finished;

   vread_top i_vread_top (
      .clk             (clk),
      .rst             (rst),
      .run_i           (run),
      .ping_pong_i     (ping_pong),
      .ext_addr_i      (ext_addr),
      .amount_i        (amount),
      .max_burst_i     (max_burst),
      .delay_i         (delay),
      .start_addr_i    (start_addr),
      .per_i           (per),
      .incr_i          (incr),
      .iter_i          (iter),
      .shift_i         (shift),
      .databus_valid_o (databus_valid),
      .databus_ready_i (databus_ready),
      .databus_addr_o  (databus_addr),
      .databus_len_o   (databus_len),
      .databus_rdata_i (databus_rdata),
      .databus_last_i  (databus_last),
      .out_valid_o     (out_valid),
      .out_data_o      (out_data),
      .done_o          (done)
   );

   databus_slave i_databus_slave (
      .clk     (clk),
      .rst     (rst),
      .valid_i (databus_valid),
      .ready_o (databus_ready),
      .addr_i  (databus_addr),
      .len_i   (databus_len),
      .rdata_o (databus_rdata),
      .last_o  (databus_last)
   );

   initial clk = 1'b0;
   always #50 clk = ~clk;

   task report_failure(input string msg);
      errors++;
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped at first error");
   endtask

   task check_data(input string name, input data_t got, input data_t exp);
      if (got !== exp) begin
         report_failure($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
      end
   endtask

   task check_addr(input string name, input ext_addr_t got, input ext_addr_t exp);
      if (got !== exp) begin
         report_failure($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
      end
   endtask

   task check_len(input string name, input burst_len_t got, input burst_len_t exp);
      if (got !== exp) begin
         report_failure($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
      end
   endtask

   // random loop whose elements all stay inside [lo, hi)
   task pick_loop(input int r, input int lo, input int hi, input bit lane_walk);
      int span;
      cfg_delay[r] = delay_t'($urandom % 16);
      cfg_per[r]   = period_t'(1 + $urandom % 8);
      cfg_iter[r]  = period_t'(1 + $urandom % 4);
      cfg_incr[r]  = elem_addr_t'($urandom % 4);
      cfg_shift[r] = elem_addr_t'($urandom % 10);
      if (lane_walk) begin
         // byte steps, odd shift crosses word boundaries
         cfg_incr[r]  = elem_addr_t'(1);
         cfg_shift[r] = elem_addr_t'(1 + 2 * ($urandom % 4));
      end
      span = (int'(cfg_per[r]) - 1) * int'(cfg_incr[r])
           + (int'(cfg_iter[r]) - 1) * int'(cfg_shift[r]);
      cfg_start[r] = elem_addr_t'(lo + $urandom % (hi - lo - span));
   endtask

   task make_configs();
      int   fill_words [2];
      int   total;
      logic bank;
      logic drain;
      fill_words[0] = 0;
      fill_words[1] = 0;
      total = 0;
      bank  = 1'b0;
      for (int r = 0; r < NUM_RUNS; r++) begin
         // run 0 fills bank 0, then ping-pong runs, then bank 0 only
         cfg_pp[r] = (r >= 1 && r <= 6);
         if (r == 0) begin
            cfg_amount[r] = mem_addr_t'(64);
         end else if (r <= 6) begin
            cfg_amount[r] = mem_addr_t'(16 + $urandom % 49);
         end else if (r == 7) begin
            cfg_amount[r] = '0;
         end else begin
            cfg_amount[r] = mem_addr_t'(1 + $urandom % 16);
         end
         case (r)
            // 64 words in bursts of 10 end on a short burst of 4
            0:       cfg_maxb[r] = burst_len_t'(10);
            2:       cfg_maxb[r] = burst_len_t'(255);
            4:       cfg_maxb[r] = burst_len_t'(1);
            default: cfg_maxb[r] = burst_len_t'(1 + $urandom % 16);
         endcase
         cfg_addr[r] = ext_addr_t'($urandom);
         cfg_addr[r][1:0] = 2'b00;
         bank  = cfg_pp[r] ? ~bank : 1'b0;
         drain = cfg_pp[r] ? ~bank : 1'b0;
         if (r == 0) begin
            pick_loop(r, 0, 64, 1'b0);
            cfg_iter[r] = '0;
         end else if (cfg_pp[r] || cfg_amount[r] == '0) begin
            pick_loop(r, 0, 4 * fill_words[drain], (r == 3 || r == 7));
         end else begin
            // stay clear of the words this run overwrites
            pick_loop(r, 4 * int'(cfg_amount[r]), 4 * fill_words[0], (r == 10));
         end
         if (int'(cfg_amount[r]) > fill_words[bank]) begin
            fill_words[bank] = int'(cfg_amount[r]);
         end
         total += int'(cfg_amount[r]) + int'(cfg_per[r]) * int'(cfg_iter[r])
                + int'(cfg_delay[r]);
      end
      limit = 4 * total + 200;
   endtask

   // expected bursts, bank contents and output bytes of one run
   task start_model(input int r);
      ext_addr_t  a;
      int         remain;
      int         beats;
      logic       drain;
      elem_addr_t ea;
      mem_word_t  word;
      a      = cfg_addr[r];
      remain = int'(cfg_amount[r]);
      while (remain > 0) begin
         beats = (remain < int'(cfg_maxb[r])) ? remain : int'(cfg_maxb[r]);
         exp_addr_q.push_back(a);
         exp_len_q.push_back(burst_len_t'(beats - 1));
         a = a + ext_addr_t'(beats * BYTES_PER_WORD);
         remain -= beats;
      end
      model_bank = cfg_pp[r] ? ~model_bank : 1'b0;
      drain      = cfg_pp[r] ? ~model_bank : 1'b0;
      for (int w = 0; w < int'(cfg_amount[r]); w++) begin
         shadow[model_bank][w] =
            i_databus_slave.read_word(cfg_addr[r] + ext_addr_t'(w * BYTES_PER_WORD));
      end
      for (int i = 0; i < int'(cfg_iter[r]); i++) begin
         for (int j = 0; j < int'(cfg_per[r]); j++) begin
            ea   = elem_addr_t'(int'(cfg_start[r]) + i * int'(cfg_shift[r])
                              + j * int'(cfg_incr[r]));
            word = shadow[drain][ea[ELEM_ADDR_W-1:LANE_W]];
            exp_data_q.push_back(word[ea[LANE_W-1:0]*DATA_W +: DATA_W]);
         end
      end
   endtask

   task run_one(input int r);
      start_model(r);
      cur_delay  = int'(cfg_delay[r]);
      cur_amount = int'(cfg_amount[r]);
      cur_reads  = int'(cfg_per[r]) * int'(cfg_iter[r]);
      @(posedge clk);
      run        <= 1'b1;
      ping_pong  <= cfg_pp[r];
      ext_addr   <= cfg_addr[r];
      amount     <= cfg_amount[r];
      max_burst  <= cfg_maxb[r];
      delay      <= cfg_delay[r];
      start_addr <= cfg_start[r];
      per        <= cfg_per[r];
      incr       <= cfg_incr[r];
      iter       <= cfg_iter[r];
      shift      <= cfg_shift[r];
      @(posedge clk);
      run <= 1'b0;
      @(run_finished);
      repeat (IDLE_CYCLES) @(posedge clk);
   endtask

   task watch_bus();
      if (databus_valid) begin
         if (!in_burst) begin
            if (exp_addr_q.size() == 0) begin
               report_failure("burst request beyond the configured amount");
            end
            burst_addr = exp_addr_q.pop_front();
            burst_len  = exp_len_q.pop_front();
            in_burst   = 1'b1;
         end
         // address and length must hold for the whole burst
         check_addr("databus_addr_o", databus_addr, burst_addr);
         check_len("databus_len_o", databus_len, burst_len);
         if (databus_ready) begin
            beat_cnt++;
            if (databus_last) begin
               in_burst = 1'b0;
            end
         end
      end
   endtask

   task watch_output();
      if (out_valid) begin
         if (exp_data_q.size() == 0) begin
            report_failure("more output words than per_i times iter_i");
         end
         if (cyc != run_cycle + cur_delay + 2 + out_cnt) begin
            report_failure($sformatf("output word %0d came at cycle %0d, expected cycle %0d",
                                     out_cnt, cyc - run_cycle, cur_delay + 2 + out_cnt));
         end
         check_data("out_data_o", out_data, exp_data_q.pop_front());
         out_cnt++;
      end
   endtask

   task finish_run();
      if (exp_addr_q.size() != 0) begin
         report_failure("done_o rose before all bursts were issued");
      end
      if (beat_cnt != cur_amount) begin
         report_failure($sformatf("fetch moved %0d beats instead of %0d", beat_cnt, cur_amount));
      end
      if (out_cnt != cur_reads) begin
         report_failure($sformatf("run gave %0d output words instead of %0d", out_cnt, cur_reads));
      end
      busy = 1'b0;
      -> run_finished;
   endtask

   always @(posedge clk) begin
      if (!rst) begin
         cyc++;
         if (cyc > limit) begin
            report_failure($sformatf("timeout, runs not finished after %0d cycles", limit));
         end
         if (run) begin
            busy        = 1'b1;
            first_cycle = 1'b1;
            in_burst    = 1'b0;
            run_cycle   = cyc;
            out_cnt     = 0;
            beat_cnt    = 0;
         end else if (!busy) begin
            if (!done) begin
               report_failure("done_o is low while no run is active");
            end
            if (databus_valid || out_valid) begin
               report_failure("DUT is active while no run is active");
            end
         end else begin
            if (first_cycle && done) begin
               report_failure("done_o did not fall after run_i");
            end
            first_cycle = 1'b0;
            watch_bus();
            watch_output();
            if (done) begin
               finish_run();
            end
         end
      end
   end

   initial begin
      rst         = 1'b1;
      run         = 1'b0;
      ping_pong   = 1'b0;
      ext_addr    = '0;
      amount      = '0;
      max_burst   = '0;
      delay       = '0;
      start_addr  = '0;
      per         = '0;
      incr        = '0;
      iter        = '0;
      shift       = '0;
      errors      = 0;
      cyc         = 0;
      limit       = 0;
      busy        = 1'b0;
      first_cycle = 1'b0;
      in_burst    = 1'b0;
      model_bank  = 1'b0;
      seed_draw   = $urandom(7202);
      i_databus_slave.fill_memory();
      make_configs();
      repeat (5) @(posedge clk);
      rst <= 1'b0;
      for (int r = 0; r < NUM_RUNS; r++) begin
         run_one(r);
      end
      repeat (IDLE_CYCLES) @(posedge clk);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
